/* test/tcb_lite_testdata.txt */
# test | m0: vld op lck adr wdt ben | m1: vld op lck adr wdt ben | rdy rsp rdt err
# hex fields, op 1 is write; rsp rdt err are due one cycle later; idle manager fields are don't-care
6 1 1 0 00 11111111 f 1 1 0 04 22222222 f 1 1 00000000 0
6 0 0 0 00 00000000 0 1 1 0 04 22222222 f 2 2 00000000 0
1 1 1 0 08 a5a5a5a5 f 0 0 0 00 00000000 0 1 1 00000000 0
1 1 1 0 08 000000cc 1 0 0 0 00 00000000 0 1 1 00000000 0
1 1 1 0 08 77000000 8 0 0 0 00 00000000 0 1 1 00000000 0
1 1 1 0 0c deadbeef f 0 0 0 00 00000000 0 1 1 00000000 0
1 1 1 0 0c 12345678 6 0 0 0 00 00000000 0 1 1 00000000 0
1 1 0 0 08 00000000 0 0 0 0 00 00000000 0 1 1 77a5a5cc 0
1 1 0 0 0c 00000000 0 0 0 0 00 00000000 0 1 1 de3456ef 0
1 1 0 0 00 00000000 0 0 0 0 00 00000000 0 1 1 11111111 0
2 1 0 0 04 00000000 0 1 0 0 08 00000000 0 1 1 22222222 0
2 1 0 0 00 00000000 0 1 0 0 08 00000000 0 1 1 11111111 0
2 0 0 0 00 00000000 0 1 0 0 08 00000000 0 2 2 77a5a5cc 0
3 0 0 0 00 00000000 0 1 1 1 10 cafef00d f 2 2 00000000 0
3 1 0 0 00 00000000 0 0 0 0 00 00000000 0 0 0 00000000 0
3 1 0 0 00 00000000 0 1 0 1 10 00000000 0 2 2 cafef00d 0
3 1 0 0 00 00000000 0 1 0 0 04 00000000 0 2 2 22222222 0
3 1 0 0 00 00000000 0 1 0 0 08 00000000 0 1 1 11111111 0
3 0 0 0 00 00000000 0 1 0 0 08 00000000 0 2 2 77a5a5cc 0
4 1 1 0 80 ffffffff f 0 0 0 00 00000000 0 1 1 00000000 1
4 0 0 0 00 00000000 0 1 0 0 fc 00000000 0 2 2 00000000 1
4 1 0 0 00 00000000 0 0 0 0 00 00000000 0 1 1 11111111 0
4 0 0 0 00 00000000 0 1 1 0 84 12345678 3 2 2 00000000 1
4 0 0 0 00 00000000 0 1 0 0 04 00000000 0 2 2 22222222 0
5 1 0 0 08 00000000 0 0 0 0 00 00000000 0 1 1 77a5a5cc 0
5 0 0 0 00 00000000 0 1 0 0 0c 00000000 0 2 2 de3456ef 0
5 1 0 0 10 00000000 0 0 0 0 00 00000000 0 1 1 cafef00d 0
5 0 0 0 00 00000000 0 1 1 0 14 0badc0de f 2 2 00000000 0
5 1 0 0 14 00000000 0 0 0 0 00 00000000 0 1 1 0badc0de 0
5 0 0 0 00 00000000 0 1 0 0 04 00000000 0 2 2 22222222 0

/* tb.f */
+incdir+hw
hw/tcb_lite_pkg.sv
hw/tcb_lite_arbiter.sv
hw/tcb_lite_req_mux.sv
hw/tcb_lite_mem.sv
hw/tcb_lite_rsp_route.sv
hw/tcb_lite_interconnect.sv
test/tb_clock.sv
test/tcb_lite_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the TCB-lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tcb_lite_tb -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtcb_lite_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi

/* test/tcb_lite_tb.sv */
/*
 * Testbench for the TCB-lite interconnect.
 * Steps come from test/tcb_lite_testdata.txt, one per clock, driven on the
 * falling edge. Grants are checked before the rising edge, responses one cycle later.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_tb;

    import tcb_lite_pkg::*;

    localparam int    MAX_STEPS    = 64;
    localparam int    MAX_TESTS    = 8;
    localparam int    RESET_TEST   = 6;
    localparam int    RESET_CYCLES = 16;
    localparam string DATA_FILE    = "test/tcb_lite_testdata.txt";

    logic                             sub;
    logic                             rst;
    logic [`TCB_IFN-1:0]              man_vld;
    tcb_op_t [`TCB_IFN-1:0]           man_op;
    logic [`TCB_IFN-1:0]              man_lck;
    logic [`TCB_IFN-1:0][`TCB_AW-1:0] man_adr;
    logic [`TCB_IFN-1:0][`TCB_DW-1:0] man_wdt;
    logic [`TCB_IFN-1:0][`TCB_BW-1:0] man_ben;
    logic [`TCB_IFN-1:0]              man_rdy;
    logic [`TCB_IFN-1:0]              man_rsp;
    logic [`TCB_IFN-1:0][`TCB_DW-1:0] man_rdt;
    logic [`TCB_IFN-1:0]              man_err;

    // step table from the data file
    int                               n_steps;
    int                               st_test [MAX_STEPS];
    logic [`TCB_IFN-1:0]              st_vld  [MAX_STEPS];
    logic [`TCB_IFN-1:0]              st_op   [MAX_STEPS];
    logic [`TCB_IFN-1:0]              st_lck  [MAX_STEPS];
    logic [`TCB_IFN-1:0][`TCB_AW-1:0] st_adr  [MAX_STEPS];
    logic [`TCB_IFN-1:0][`TCB_DW-1:0] st_wdt  [MAX_STEPS];
    logic [`TCB_IFN-1:0][`TCB_BW-1:0] st_ben  [MAX_STEPS];
    logic [`TCB_IFN-1:0]              st_rdy  [MAX_STEPS];
    logic [`TCB_IFN-1:0]              st_rsp  [MAX_STEPS];
    logic [`TCB_DW-1:0]               st_rdt  [MAX_STEPS];
    logic                             st_err  [MAX_STEPS];

    // bookkeeping
    int test_err [MAX_TESTS];
    int fail_cnt;
    int tests_pass;
    int tests_fail;
    int limit_ns;
    bit loaded;

    tb_clock clk_gen (.sub(sub));

    tcb_lite_interconnect DUT (
        .sub     (sub),
        .rst     (rst),
        .man_vld (man_vld),
        .man_op  (man_op),
        .man_lck (man_lck),
        .man_adr (man_adr),
        .man_wdt (man_wdt),
        .man_ben (man_ben),
        .man_rdy (man_rdy),
        .man_rsp (man_rsp),
        .man_rdt (man_rdt),
        .man_err (man_err)
    );

    //////////////////////////////////////////////////
    // data file
    //////////////////////////////////////////////////

    // false for blank and comment lines
    function automatic bit has_fields(input string s);
        for (int i = 0; i < s.len(); i++) begin
            if (s[i] == "#") return 1'b0;
            if (s[i] != " " && s[i] != "\t" && s[i] != "\n" && s[i] != "\r") return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic load_steps(output bit ok);
        int          fd;
        int          got;
        int          lno;
        string       line;
        int          t, v0, o0, l0, a0, b0, v1, o1, l1, a1, b1, rdy, rsp, err;
        logic [31:0] w0, w1, rdt;
        bit          bad;
        ok = 1'b1;
        n_steps = 0;
        lno = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open data file %s", DATA_FILE);
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                got = $fgets(line, fd);
                lno++;
                if (got > 0 && has_fields(line)) begin
                    got = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  t, v0, o0, l0, a0, w0, b0, v1, o1, l1, a1, w1, b1,
                                  rdy, rsp, rdt, err);
                    // every field must fit its bus width
                    bad = (got != 17) || (t < 0) || (t >= MAX_TESTS) || (err > 1);
                    bad = bad || (v0 > 1) || (o0 > 1) || (l0 > 1) || (v1 > 1) || (o1 > 1);
                    bad = bad || (l1 > 1) || (a0 >= (1 << `TCB_AW)) || (a1 >= (1 << `TCB_AW));
                    bad = bad || (b0 >= (1 << `TCB_BW)) || (b1 >= (1 << `TCB_BW));
                    bad = bad || (rdy >= (1 << `TCB_IFN)) || (rsp >= (1 << `TCB_IFN));
                    if (bad || n_steps >= MAX_STEPS) begin
                        $display("data file line %0d is malformed or past the step limit", lno);
                        ok = 1'b0;
                    end else begin
                        st_test[n_steps] = t;
                        st_vld[n_steps]  = {v1[0], v0[0]};
                        st_op[n_steps]   = {o1[0], o0[0]};
                        st_lck[n_steps]  = {l1[0], l0[0]};
                        st_adr[n_steps]  = {a1[`TCB_AW-1:0], a0[`TCB_AW-1:0]};
                        st_wdt[n_steps]  = {w1, w0};
                        st_ben[n_steps]  = {b1[`TCB_BW-1:0], b0[`TCB_BW-1:0]};
                        st_rdy[n_steps]  = rdy[`TCB_IFN-1:0];
                        st_rsp[n_steps]  = rsp[`TCB_IFN-1:0];
                        st_rdt[n_steps]  = rdt;
                        st_err[n_steps]  = err[0];
                        n_steps++;
                    end
                end
            end
            $fclose(fd);
            if (ok && n_steps == 0) begin
                $display("data file %s holds no steps", DATA_FILE);
                ok = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // idle fields are don't-care and get random values
    task automatic drive_random(input int i, input logic vld);
        logic [31:0] rnd;
        rnd = $urandom;
        man_vld[i] = vld;
        man_op[i]  = rnd[0] ? TCB_WRITE : TCB_READ;
        man_lck[i] = rnd[1];
        man_ben[i] = rnd[4 +: `TCB_BW];
        man_adr[i] = rnd[8 +: `TCB_AW];
        man_wdt[i] = $urandom;
    endtask

    task automatic drive_step(input int k);
        for (int i = 0; i < `TCB_IFN; i++) begin
            if (st_vld[k][i]) begin
                man_vld[i] = 1'b1;
                man_op[i]  = st_op[k][i] ? TCB_WRITE : TCB_READ;
                man_lck[i] = st_lck[k][i];
                man_adr[i] = st_adr[k][i];
                man_wdt[i] = st_wdt[k][i];
                man_ben[i] = st_ben[k][i];
            end else begin
                drive_random(i, 1'b0);
            end
        end
    endtask

    // read data is checked on reads and on errored transfers
    function automatic logic [`TCB_IFN-1:0] data_mask(input int k);
        logic [`TCB_IFN-1:0] m;
        for (int i = 0; i < `TCB_IFN; i++) begin
            m[i] = (tcb_op_t'(st_op[k][i]) == TCB_READ) || st_err[k];
        end
        return m;
    endfunction

    //////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////

    task automatic note_fail(input int tst);
        fail_cnt++;
        test_err[tst]++;
    endtask

    task automatic check_grant(input int tst, input logic [`TCB_IFN-1:0] exp_rdy);
        arb_state_t st;
        st = DUT.arb.state;
        if (man_rdy !== exp_rdy) begin
            $display("MISMATCH %0t ns test %0d: man_rdy %b, expected %b, arbiter %s",
                     $time, tst, man_rdy, exp_rdy, st.name());
            note_fail(tst);
        end
    endtask

    task automatic check_rsp(input int tst, input logic [`TCB_IFN-1:0] exp_rsp,
                             input logic [`TCB_DW-1:0] exp_rdt, input logic exp_err,
                             input logic [`TCB_IFN-1:0] dat_chk);
        logic [`TCB_DW-1:0] want;
        if (man_rsp !== exp_rsp) begin
            $display("MISMATCH %0t ns test %0d: man_rsp %b, expected %b",
                     $time, tst, man_rsp, exp_rsp);
            note_fail(tst);
        end
        // non-responding managers see zero
        for (int i = 0; i < `TCB_IFN; i++) begin
            want = exp_rsp[i] ? exp_rdt : '0;
            if (man_err[i] !== (exp_rsp[i] & exp_err)) begin
                $display("MISMATCH %0t ns test %0d: man_err[%0d] %b, expected %b",
                         $time, tst, i, man_err[i], exp_rsp[i] & exp_err);
                note_fail(tst);
            end
            if ((!exp_rsp[i] || dat_chk[i]) && man_rdt[i] !== want) begin
                $display("MISMATCH %0t ns test %0d: man_rdt[%0d] %h, expected %h",
                         $time, tst, i, man_rdt[i], want);
                note_fail(tst);
            end
        end
    endtask

    task automatic report_test(input int tst);
        if (test_err[tst] == 0) begin
            $display("test %0d passed", tst);
            tests_pass++;
        end else begin
            $display("test %0d failed with %0d mismatches", tst, test_err[tst]);
            tests_fail++;
        end
    endtask

    task automatic end_run(input bit ok);
        if (ok) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        bit ok;
        int last;
        void'($urandom(9));
        rst = 1'b1;
        for (int i = 0; i < `TCB_IFN; i++) begin
            drive_random(i, 1'b1);
        end
        load_steps(ok);
        if (!ok) begin
            end_run(1'b0);
        end else begin
            limit_ns = 20 * 8 * n_steps + RESET_CYCLES * 8;
            loaded = 1'b1;
            // both managers valid in reset while ready and response stay low
            // the first step's falling edge closes the last reset cycle
            repeat (RESET_CYCLES - 1) begin
                @(negedge sub);
                #3;
                check_grant(RESET_TEST, '0);
                check_rsp(RESET_TEST, '0, '0, 1'b0, '1);
            end
            for (int k = 0; k < n_steps; k++) begin
                @(negedge sub);
                rst = 1'b0;
                drive_step(k);
                #3;
                check_grant(st_test[k], st_rdy[k]);
                if (k == 0) begin
                    check_rsp(RESET_TEST, '0, '0, 1'b0, '1);
                    if (st_test[0] != RESET_TEST) report_test(RESET_TEST);
                end else begin
                    check_rsp(st_test[k-1], st_rsp[k-1], st_rdt[k-1], st_err[k-1],
                              data_mask(k-1));
                    if (st_test[k-1] != st_test[k]) report_test(st_test[k-1]);
                end
            end
            // idle cycle collects the last response
            last = n_steps - 1;
            @(negedge sub);
            for (int i = 0; i < `TCB_IFN; i++) begin
                drive_random(i, 1'b0);
            end
            #3;
            check_grant(st_test[last], '0);
            check_rsp(st_test[last], st_rsp[last], st_rdt[last], st_err[last], data_mask(last));
            report_test(st_test[last]);
            $display("summary: %0d passed, %0d failed, %0d mismatches",
                     tests_pass, tests_fail, fail_cnt);
            end_run(tests_fail == 0);
        end
    end

    initial begin
        wait (loaded);
        #(limit_ns);
        $display("watchdog: run did not finish within %0d ns", limit_ns);
        end_run(1'b0);
    end

endmodule

/* test/tb_clock.sv */
/*
 * Testbench clock source for the TCB-lite interconnect.
 * Free running, 8 ns period, starts low.
 */

`timescale 1ns/1ns

module tb_clock (
    output logic sub
);

    // half period in ns
    localparam int HALF = 4;

    initial begin
        sub = 1'b0;
        forever #HALF sub = ~sub;
    end

endmodule

/* hw/tcb_lite_interconnect.sv */
/*
 * TCB-lite interconnect top, two managers sharing one memory.
 * Arbiter grants one manager, the multiplexer forwards its request,
 * the router returns the response one cycle later.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_interconnect (
    input  logic                                 sub,
    input  logic                                 rst,
    // manager requests
    input  logic [`TCB_IFN-1:0]                  man_vld,
    input  tcb_lite_pkg::tcb_op_t [`TCB_IFN-1:0] man_op,
    input  logic [`TCB_IFN-1:0]                  man_lck,
    input  logic [`TCB_IFN-1:0][`TCB_AW-1:0]     man_adr,
    input  logic [`TCB_IFN-1:0][`TCB_DW-1:0]     man_wdt,
    input  logic [`TCB_IFN-1:0][`TCB_BW-1:0]     man_ben,
    // handshake and response toward managers
    output logic [`TCB_IFN-1:0]                  man_rdy,
    output logic [`TCB_IFN-1:0]                  man_rsp,
    output logic [`TCB_IFN-1:0][`TCB_DW-1:0]     man_rdt,
    output logic [`TCB_IFN-1:0]                  man_err
);

    import tcb_lite_pkg::*;

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////

    // arbiter control
    logic [`TCB_IFL-1:0] sel;
    logic                trn;
    // request toward memory
    tcb_op_t             sub_op;
    logic [`TCB_AW-1:0]  sub_adr;
    logic [`TCB_DW-1:0]  sub_wdt;
    logic [`TCB_BW-1:0]  sub_ben;
    // memory response
    logic [`TCB_DW-1:0]  sub_rdt;
    logic                sub_err;

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    tcb_lite_arbiter arb (
        .sub     (sub),
        .rst     (rst),
        .man_vld (man_vld),
        .man_lck (man_lck),
        .man_rdy (man_rdy),
        .sel     (sel),
        .trn     (trn)
    );

    tcb_lite_req_mux mux (
        .sel     (sel),
        .man_op  (man_op),
        .man_adr (man_adr),
        .man_wdt (man_wdt),
        .man_ben (man_ben),
        .sub_op  (sub_op),
        .sub_adr (sub_adr),
        .sub_wdt (sub_wdt),
        .sub_ben (sub_ben)
    );

    tcb_lite_mem mem (
        .sub     (sub),
        .rst     (rst),
        .trn     (trn),
        .sub_op  (sub_op),
        .sub_adr (sub_adr),
        .sub_wdt (sub_wdt),
        .sub_ben (sub_ben),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err)
    );

    tcb_lite_rsp_route rsp (
        .sub     (sub),
        .rst     (rst),
        .trn     (trn),
        .sel     (sel),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err),
        .man_rsp (man_rsp),
        .man_rdt (man_rdt),
        .man_err (man_err)
    );

endmodule

/* hw/tcb_lite_rsp_route.sv */
/*
 * Response router, returns memory read data and error to the manager
 * that issued the transfer. One registered stage, aligned with the
 * registered memory output.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_rsp_route (
    input  logic                             sub,
    input  logic                             rst,
    // transfer strobe and issuing index from arbiter
    input  logic                             trn,
    input  logic [`TCB_IFL-1:0]              sel,
    // response from memory
    input  logic [`TCB_DW-1:0]               sub_rdt,
    input  logic                             sub_err,
    // per manager response
    output logic [`TCB_IFN-1:0]              man_rsp,
    output logic [`TCB_IFN-1:0][`TCB_DW-1:0] man_rdt,
    output logic [`TCB_IFN-1:0]              man_err
);

    // response pending this cycle
    logic                rsp_q;
    // manager that issued it
    logic [`TCB_IFL-1:0] sel_q;

    //////////////////////////////////////////////////
    // issue tracking
    //////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (rst) begin
            rsp_q <= 1'b0;
        end else begin
            rsp_q <= trn;
        end
    end

    // only meaningful while rsp_q is high
    always_ff @(posedge sub) begin
        if (trn) begin
            sel_q <= sel;
        end
    end

    //////////////////////////////////////////////////
    // delivery
    //////////////////////////////////////////////////

    // issuing manager gets pulse, data and error, the others get zero
    always_comb begin
        man_rsp = '0;
        man_rdt = '0;
        man_err = '0;
        for (int i = 0; i < `TCB_IFN; i++) begin
            if (rsp_q && (sel_q == i[`TCB_IFL-1:0])) begin
                man_rsp[i] = 1'b1;
                man_rdt[i] = sub_rdt;
                man_err[i] = sub_err;
            end
        end
    end

endmodule

/* hw/tcb_lite_mem.sv */
/*
 * Word-wide memory subordinate with byte enables.
 * Writes on the transfer edge, read data and error are registered and
 * valid the cycle after. Out-of-range accesses flag an error and read zero.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_mem (
    input  logic                  sub,
    input  logic                  rst,
    // request from multiplexer
    input  logic                  trn,
    input  tcb_lite_pkg::tcb_op_t sub_op,
    input  logic [`TCB_AW-1:0]    sub_adr,
    input  logic [`TCB_DW-1:0]    sub_wdt,
    input  logic [`TCB_BW-1:0]    sub_ben,
    // response, one cycle after the transfer
    output logic [`TCB_DW-1:0]    sub_rdt,
    output logic                  sub_err
);

    import tcb_lite_pkg::*;

    // memory index width
    localparam int unsigned MAW = $clog2(`TCB_MEM_WORDS);

    // storage array
    logic [`TCB_DW-1:0] mem [0:`TCB_MEM_WORDS-1];

    // word index, byte offset bits dropped
    logic [`TCB_AW-3:0] wrd;
    logic               in_rng;

    assign wrd    = sub_adr[`TCB_AW-1:2];
    assign in_rng = (wrd < `TCB_MEM_WORDS);

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    // only enabled bytes change, out of range writes are dropped
    always_ff @(posedge sub) begin
        if (trn && in_rng && (sub_op == TCB_WRITE)) begin
            for (int b = 0; b < `TCB_BW; b++) begin
                if (sub_ben[b]) begin
                    mem[wrd[MAW-1:0]][8*b +: 8] <= sub_wdt[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // read port and error
    //////////////////////////////////////////////////

    // addressed word captured on every transfer, old value on a write
    always_ff @(posedge sub) begin
        if (trn) begin
            sub_rdt <= in_rng ? mem[wrd[MAW-1:0]] : '0;
        end
    end

    // error flag
    always_ff @(posedge sub) begin
        if (rst) begin
            sub_err <= 1'b0;
        end else if (trn) begin
            sub_err <= !in_rng;
        end
    end

endmodule

/* hw/tcb_lite_req_mux.sv */
/*
 * Request multiplexer, routes the granted manager's request fields
 * toward the memory subordinate. Purely combinational, driven by the
 * arbiter select.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_req_mux (
    // grant from arbiter
    input  logic [`TCB_IFL-1:0]                   sel,
    // manager request fields
    input  tcb_lite_pkg::tcb_op_t [`TCB_IFN-1:0]  man_op,
    input  logic [`TCB_IFN-1:0][`TCB_AW-1:0]      man_adr,
    input  logic [`TCB_IFN-1:0][`TCB_DW-1:0]      man_wdt,
    input  logic [`TCB_IFN-1:0][`TCB_BW-1:0]      man_ben,
    // request toward subordinate
    output tcb_lite_pkg::tcb_op_t                 sub_op,
    output logic [`TCB_AW-1:0]                    sub_adr,
    output logic [`TCB_DW-1:0]                    sub_wdt,
    output logic [`TCB_BW-1:0]                    sub_ben
);

    //////////////////////////////////////////////////
    // control fields
    //////////////////////////////////////////////////

    // opcode and address straight from the granted manager
    assign sub_op  = man_op[sel];
    assign sub_adr = man_adr[sel];

    //////////////////////////////////////////////////
    // byte lanes
    //////////////////////////////////////////////////

    // per lane routing of enable and data
    // disabled lanes carry zero so stale data never reaches the memory
    always_comb begin
        sub_ben = '0;
        sub_wdt = '0;
        for (int b = 0; b < `TCB_BW; b++) begin
            sub_ben[b] = man_ben[sel][b];
            if (man_ben[sel][b]) begin
                sub_wdt[8*b +: 8] = man_wdt[sel][8*b +: 8];
            end
        end
    end

endmodule

/* hw/tcb_lite_arbiter.sv */
/*
 * Fixed priority arbiter for the TCB-lite interconnect, lower index wins.
 * A locked transfer keeps the grant on its manager until that manager
 * completes a transfer without the lock flag.
 */

`timescale 1ns/1ns

`include "tcb_lite_defines.svh"

module tcb_lite_arbiter (
    input  logic                sub,
    input  logic                rst,
    // manager requests
    input  logic [`TCB_IFN-1:0] man_vld,
    input  logic [`TCB_IFN-1:0] man_lck,
    // grant toward managers and datapath
    output logic [`TCB_IFN-1:0] man_rdy,
    output logic [`TCB_IFL-1:0] sel,
    output logic                trn
);

    import tcb_lite_pkg::*;

    // lock state and the index it holds
    arb_state_t          state;
    logic [`TCB_IFL-1:0] sel_reg;
    // priority pick from current valids
    logic [`TCB_IFL-1:0] sel_cmb;

    //////////////////////////////////////////////////
    // fixed priority select
    //////////////////////////////////////////////////

    // scan from the top so the lowest valid index ends up winning
    always_comb begin
        sel_cmb = '0;
        for (int i = `TCB_IFN-1; i >= 0; i--) begin
            if (man_vld[i]) begin
                sel_cmb = i[`TCB_IFL-1:0];
            end
        end
    end

    // locked grant overrides priority, even for a higher priority manager
    assign sel = (state == ARB_LOCKED) ? sel_reg : sel_cmb;

    // ready only to the selected manager, none while in reset
    always_comb begin
        man_rdy = '0;
        if (!rst) begin
            man_rdy[sel] = man_vld[sel];
        end
    end

    // transfer strobe, selected manager valid and ready
    assign trn = man_rdy[sel];

    //////////////////////////////////////////////////
    // lock tracking
    //////////////////////////////////////////////////

    // each transfer decides the next state from its lock flag
    always_ff @(posedge sub) begin
        if (rst) begin
            state <= ARB_OPEN;
        end else if (trn) begin
            state <= man_lck[sel] ? ARB_LOCKED : ARB_OPEN;
        end
    end

    // only read back while locked
    always_ff @(posedge sub) begin
        if (trn && man_lck[sel]) begin
            sel_reg <= sel;
        end
    end

endmodule

/* hw/tcb_lite_pkg.sv */
/*
 * TCB-lite shared types.
 * Bus opcode used on manager ports and toward the memory,
 * arbiter lock state used inside the arbiter.
 */

package tcb_lite_pkg;

    //////////////////////////////////////////////////
    // bus opcode
    //////////////////////////////////////////////////

    // one bit on the wire, read is the idle default
    typedef enum logic {
        TCB_READ  = 1'b0,
        TCB_WRITE = 1'b1
    } tcb_op_t;

    //////////////////////////////////////////////////
    // arbiter lock state
    //////////////////////////////////////////////////

    // open: grant follows fixed priority each cycle
    // locked: grant stays on the recorded manager
    typedef enum logic {
        ARB_OPEN   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_t;

endpackage

/* hw/tcb_lite_defines.svh */
/*
 * TCB-lite interconnect sizing macros.
 * Include wherever bus widths, manager count or memory depth are needed.
 * Manager count is global; modules carry no sizing parameters.
 */

`ifndef TCB_LITE_DEFINES_SVH
`define TCB_LITE_DEFINES_SVH

//////////////////////////////////////////////////
// manager side
//////////////////////////////////////////////////

// number of bus managers
`define TCB_IFN 2
// width of a manager index
`define TCB_IFL 1

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

// byte address, word aligned
`define TCB_AW 8
// data word, 4 bytes
`define TCB_DW 32
// one enable per data byte
`define TCB_BW 4

// memory depth in words, higher word indexes are out of range
`define TCB_MEM_WORDS 32

`endif
